// ==== tb.f ====
hw/or1k_spr_pkg.sv
hw/or1k_except_pkg.sv
hw/or1k_pic.sv
hw/or1k_tick_timer.sv
hw/or1k_supervision_ctrl.sv
hw/or1k_ctrl_unit.sv
verif/tb_or1k_ctrl_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_or1k_ctrl_unit -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Done: errors found" sim.log \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// ==== verif/tb_or1k_ctrl_unit.sv ====
// Control unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_or1k_ctrl_unit;
   import or1k_spr_pkg::*;

   localparam int       NUM_IRQ   = 32;
   localparam operand_t RESET_PC  = 32'h0000_0100;
   localparam operand_t EVBAR_VAL = 32'h0000_2000;
   localparam operand_t LSU_ADR   = 32'h0000_8a36;
   // Continuous mode, interrupt enable, period 20
   localparam operand_t TTMR_VAL  = 32'hE000_0014;

   // Cause bits ordered bus error, illegal, alignment, syscall, trap
   localparam logic [4:0] C_NONE  = 5'b00000;
   localparam logic [4:0] C_ALL   = 5'b11111;
   localparam logic [4:0] C_ILSYS = 5'b01010;
   localparam logic [4:0] C_ALIGN = 5'b00100;
   localparam logic [4:0] C_SYS   = 5'b00010;
   localparam logic [4:0] C_TRAP  = 5'b00001;

   typedef enum logic [2:0] {
      OP_MTSPR, OP_MFSPR, OP_EXCEPT, OP_RFE, OP_IRQ, OP_WAITBR, OP_SR, OP_NOBR
   } op_kind_t;

   typedef struct packed {
      op_kind_t   kind;
      spr_addr_t  addr;
      operand_t   data;
      logic [4:0] cause;
      operand_t   expected;
   } step_t;

   logic               clk;
   logic               rst;
   logic               padv_ctrl_i;
   logic               op_mtspr_i;
   logic               op_mfspr_i;
   logic               op_rfe_i;
   operand_t           pc_ctrl_i;
   spr_addr_t          spr_addr_i;
   operand_t           spr_wdat_i;
   operand_t           lsu_adr_i;
   logic               except_ibus_err_i;
   logic               except_illegal_i;
   logic               except_align_i;
   logic               except_syscall_i;
   logic               except_trap_i;
   logic               fetch_branch_taken_i;
   logic [NUM_IRQ-1:0] irq_i;
   logic [4:0]         cause_bits;
   operand_t           mfspr_dat_o;
   logic               ctrl_branch_exception_o;
   operand_t           ctrl_branch_except_pc_o;
   logic               pipeline_flush_o;
   sr_t                spr_sr_o;

   step_t steps[$];
   string names[$];
   int    checks = 0;
   int    errors = 0;
   int    cycles = 0;
   int    cycle_limit = 0;

   assign {except_ibus_err_i, except_illegal_i, except_align_i,
           except_syscall_i, except_trap_i} = cause_bits;

   or1k_ctrl_unit #(
      .RESET_PC (RESET_PC),
      .NUM_IRQ  (NUM_IRQ)
   ) or1k_ctrl_unit_inst (
      .clk                     (clk),
      .rst                     (rst),
      .padv_ctrl_i             (padv_ctrl_i),
      .op_mtspr_i              (op_mtspr_i),
      .op_mfspr_i              (op_mfspr_i),
      .op_rfe_i                (op_rfe_i),
      .pc_ctrl_i               (pc_ctrl_i),
      .spr_addr_i              (spr_addr_i),
      .spr_wdat_i              (spr_wdat_i),
      .lsu_adr_i               (lsu_adr_i),
      .except_ibus_err_i       (except_ibus_err_i),
      .except_illegal_i        (except_illegal_i),
      .except_align_i          (except_align_i),
      .except_syscall_i        (except_syscall_i),
      .except_trap_i           (except_trap_i),
      .fetch_branch_taken_i    (fetch_branch_taken_i),
      .irq_i                   (irq_i),
      .mfspr_dat_o             (mfspr_dat_o),
      .ctrl_branch_exception_o (ctrl_branch_exception_o),
      .ctrl_branch_except_pc_o (ctrl_branch_except_pc_o),
      .pipeline_flush_o        (pipeline_flush_o),
      .spr_sr_o                (spr_sr_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_word(input string name, input operand_t exp, input operand_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_sr(input string name, input sr_t exp, input sr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic add_step(input string name, input op_kind_t kind, input spr_addr_t addr,
                           input operand_t data, input logic [4:0] cause,
                           input operand_t expected);
      step_t st;
      st.kind     = kind;
      st.addr     = addr;
      st.data     = data;
      st.cause    = cause;
      st.expected = expected;
      steps.push_back(st);
      names.push_back(name);
   endtask

   task automatic write_spr(input spr_addr_t addr, input operand_t data);
      @(posedge clk);
      padv_ctrl_i <= 1'b1;
      op_mtspr_i  <= 1'b1;
      spr_addr_i  <= addr;
      spr_wdat_i  <= data;
      @(posedge clk);
      padv_ctrl_i <= 1'b0;
      op_mtspr_i  <= 1'b0;
   endtask

   task automatic read_spr(input string name, input spr_addr_t addr, input operand_t exp);
      @(posedge clk);
      op_mfspr_i <= 1'b1;
      spr_addr_i <= addr;
      @(negedge clk);
      check_word(name, exp, mfspr_dat_o);
      @(posedge clk);
      op_mfspr_i <= 1'b0;
   endtask

   // Acts as fetch, accepting two cycles after the request is seen
   task automatic take_branch(input string name, input operand_t exp_pc);
      while (ctrl_branch_exception_o !== 1'b1)
         @(negedge clk);
      check_word({name, " vector"}, exp_pc, ctrl_branch_except_pc_o);
      @(posedge clk);
      padv_ctrl_i <= 1'b0;
      op_rfe_i    <= 1'b0;
      cause_bits  <= C_NONE;
      @(posedge clk);
      fetch_branch_taken_i <= 1'b1;
      @(posedge clk);
      fetch_branch_taken_i <= 1'b0;
      @(negedge clk);
      check_bit({name, " released"}, 1'b0, ctrl_branch_exception_o);
   endtask

   task automatic raise_exception(input string name, input logic [4:0] cause,
                                  input operand_t pc, input operand_t exp_pc);
      @(posedge clk);
      padv_ctrl_i <= 1'b1;
      pc_ctrl_i   <= pc;
      cause_bits  <= cause;
      @(negedge clk);
      check_bit({name, " flush"}, 1'b1, pipeline_flush_o);
      take_branch(name, exp_pc);
   endtask

   task automatic return_from_exception(input string name, input operand_t exp_pc);
      @(posedge clk);
      padv_ctrl_i <= 1'b1;
      op_rfe_i    <= 1'b1;
      @(negedge clk);
      check_bit({name, " flush"}, 1'b1, pipeline_flush_o);
      take_branch(name, exp_pc);
   endtask

   // Plain instructions complete every cycle until an interrupt is taken
   task automatic run_until_branch(input string name, input operand_t pc,
                                   input operand_t exp_pc);
      @(posedge clk);
      padv_ctrl_i <= 1'b1;
      pc_ctrl_i   <= pc;
      @(negedge clk);
      take_branch(name, exp_pc);
   endtask

   task automatic expect_no_branch(input string name, input operand_t pc);
      @(posedge clk);
      padv_ctrl_i <= 1'b1;
      pc_ctrl_i   <= pc;
      @(negedge clk);
      check_bit({name, " flush"}, 1'b0, pipeline_flush_o);
      @(posedge clk);
      padv_ctrl_i <= 1'b0;
      @(negedge clk);
      check_bit({name, " request"}, 1'b0, ctrl_branch_exception_o);
   endtask

   task automatic build_table();
      operand_t r_evbar;
      operand_t r_esr;
      operand_t r_epcr;
      operand_t r_picmr;
      operand_t r_ttmr;
      r_evbar = $urandom();
      r_esr   = $urandom();
      r_epcr  = $urandom();
      r_picmr = $urandom();
      // Mode 00 keeps the timer idle so TTMR reads back unchanged
      r_ttmr  = $urandom() & 32'h3FFF_FFFF;
      add_step("reset epcr", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, RESET_PC);
      add_step("reset sr", OP_SR, '0, '0, C_NONE, 32'h0000_8001);
      add_step("evbar write", OP_MTSPR, SPR_EVBAR_ADDR, r_evbar, C_NONE, '0);
      add_step("evbar read", OP_MFSPR, SPR_EVBAR_ADDR, '0, C_NONE, r_evbar & ~32'h0000_1FFF);
      add_step("esr write", OP_MTSPR, SPR_ESR0_ADDR, r_esr, C_NONE, '0);
      add_step("esr read", OP_MFSPR, SPR_ESR0_ADDR, '0, C_NONE, {16'h0000, r_esr[15:0]});
      add_step("epcr write", OP_MTSPR, SPR_EPCR0_ADDR, r_epcr, C_NONE, '0);
      add_step("epcr read", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, r_epcr);
      add_step("picmr write", OP_MTSPR, SPR_PICMR_ADDR, r_picmr, C_NONE, '0);
      add_step("picmr read", OP_MFSPR, SPR_PICMR_ADDR, '0, C_NONE, r_picmr);
      add_step("ttmr write", OP_MTSPR, SPR_TTMR_ADDR, r_ttmr, C_NONE, '0);
      add_step("ttmr read", OP_MFSPR, SPR_TTMR_ADDR, '0, C_NONE, r_ttmr);
      add_step("ttmr clear", OP_MTSPR, SPR_TTMR_ADDR, '0, C_NONE, '0);
      add_step("unknown sys read", OP_MFSPR, 16'h0050, '0, C_NONE, '0);
      add_step("unknown group read", OP_MFSPR, 16'h2805, '0, C_NONE, '0);
      add_step("evbar set", OP_MTSPR, SPR_EVBAR_ADDR, EVBAR_VAL, C_NONE, '0);
      add_step("sr write", OP_MTSPR, SPR_SR_ADDR, 32'h0000_8007, C_NONE, '0);
      add_step("sr before syscall", OP_SR, '0, '0, C_NONE, 32'h0000_8007);
      add_step("syscall", OP_EXCEPT, '0, 32'h0000_1230, C_SYS, EVBAR_VAL | 32'h0C00);
      add_step("syscall epcr", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, 32'h0000_1234);
      add_step("syscall esr", OP_MFSPR, SPR_ESR0_ADDR, '0, C_NONE, 32'h0000_8007);
      add_step("syscall sr", OP_SR, '0, '0, C_NONE, 32'h0000_8001);
      add_step("illegal over syscall", OP_EXCEPT, '0, 32'h0000_1300, C_ILSYS,
               EVBAR_VAL | 32'h0700);
      add_step("illegal epcr", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, 32'h0000_1300);
      add_step("bus error first", OP_EXCEPT, '0, 32'h0000_1400, C_ALL, EVBAR_VAL | 32'h0200);
      add_step("bus error eear", OP_MFSPR, SPR_EEAR0_ADDR, '0, C_NONE, 32'h0000_1400);
      add_step("alignment", OP_EXCEPT, '0, 32'h0000_1500, C_ALIGN, EVBAR_VAL | 32'h0600);
      add_step("alignment eear", OP_MFSPR, SPR_EEAR0_ADDR, '0, C_NONE, LSU_ADR);
      add_step("trap", OP_EXCEPT, '0, 32'h0000_1600, C_TRAP, EVBAR_VAL | 32'h0E00);
      add_step("esr for rfe", OP_MTSPR, SPR_ESR0_ADDR, 32'h0000_8401, C_NONE, '0);
      add_step("rfe", OP_RFE, '0, '0, C_NONE, 32'h0000_1600);
      add_step("sr after rfe", OP_SR, '0, '0, C_NONE, 32'h0000_8401);
      add_step("sr iee on", OP_MTSPR, SPR_SR_ADDR, 32'h0000_8005, C_NONE, '0);
      add_step("picmr line 4", OP_MTSPR, SPR_PICMR_ADDR, 32'h0000_0010, C_NONE, '0);
      add_step("irq lines 0 and 4", OP_IRQ, '0, 32'h0000_0011, C_NONE, '0);
      add_step("picsr masked", OP_MFSPR, SPR_PICSR_ADDR, '0, C_NONE, 32'h0000_0010);
      add_step("pic entry", OP_WAITBR, '0, 32'h0000_1700, C_NONE, EVBAR_VAL | 32'h0800);
      add_step("pic epcr", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, 32'h0000_1704);
      add_step("irq off", OP_IRQ, '0, '0, C_NONE, '0);
      add_step("sr iee again", OP_MTSPR, SPR_SR_ADDR, 32'h0000_8005, C_NONE, '0);
      add_step("irq line 0", OP_IRQ, '0, 32'h0000_0001, C_NONE, '0);
      add_step("masked line", OP_NOBR, '0, 32'h0000_1800, C_NONE, '0);
      add_step("picsr all masked", OP_MFSPR, SPR_PICSR_ADDR, '0, C_NONE, '0);
      add_step("irq off again", OP_IRQ, '0, '0, C_NONE, '0);
      add_step("sr tee on", OP_MTSPR, SPR_SR_ADDR, 32'h0000_8003, C_NONE, '0);
      add_step("ttcr clear", OP_MTSPR, SPR_TTCR_ADDR, '0, C_NONE, '0);
      add_step("ttmr start", OP_MTSPR, SPR_TTMR_ADDR, TTMR_VAL, C_NONE, '0);
      add_step("timer entry", OP_WAITBR, '0, 32'h0000_1900, C_NONE, EVBAR_VAL | 32'h0500);
      add_step("ttmr pending", OP_MFSPR, SPR_TTMR_ADDR, '0, C_NONE, TTMR_VAL | 32'h1000_0000);
      add_step("timer epcr", OP_MFSPR, SPR_EPCR0_ADDR, '0, C_NONE, 32'h0000_1904);
      add_step("ttmr stop", OP_MTSPR, SPR_TTMR_ADDR, '0, C_NONE, '0);
      add_step("timer sr", OP_SR, '0, '0, C_NONE, 32'h0000_8001);
   endtask

   initial begin
      wait (cycle_limit != 0);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      errors++;
      $display("Timeout: the test sequence did not finish within %0d cycles", cycle_limit);
      $display("Closing: %0d checks, %0d errors", checks, errors);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      step_t st;
      void'($urandom(32'h0c54_7401));
      build_table();
      cycle_limit = steps.size() * 64;
      rst                  <= 1'b1;
      padv_ctrl_i          <= 1'b0;
      op_mtspr_i           <= 1'b0;
      op_mfspr_i           <= 1'b0;
      op_rfe_i             <= 1'b0;
      pc_ctrl_i            <= '0;
      spr_addr_i           <= '0;
      spr_wdat_i           <= '0;
      lsu_adr_i            <= LSU_ADR;
      cause_bits           <= C_NONE;
      fetch_branch_taken_i <= 1'b0;
      irq_i                <= '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_bit("reset request", 1'b0, ctrl_branch_exception_o);
      check_bit("reset flush", 1'b0, pipeline_flush_o);
      for (int i = 0; i < steps.size(); i++) begin
         st = steps[i];
         case (st.kind)
            OP_MTSPR:  write_spr(st.addr, st.data);
            OP_MFSPR:  read_spr(names[i], st.addr, st.expected);
            OP_EXCEPT: raise_exception(names[i], st.cause, st.data, st.expected);
            OP_RFE:    return_from_exception(names[i], st.expected);
            OP_WAITBR: run_until_branch(names[i], st.data, st.expected);
            OP_NOBR:   expect_no_branch(names[i], st.data);
            OP_IRQ: begin
               @(posedge clk);
               irq_i <= st.data;
            end
            default: begin
               @(negedge clk);
               check_sr(names[i], st.expected[15:0], spr_sr_o);
            end
         endcase
      end
      $display("Closing: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/or1k_ctrl_unit.sv ====
// OpenRISC control unit
`timescale 1ns/100ps
`default_nettype none

module or1k_ctrl_unit #(
   parameter or1k_spr_pkg::operand_t RESET_PC = 32'h0000_0100,
   parameter int                     NUM_IRQ  = 32
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    padv_ctrl_i,
   input  wire logic                    op_mtspr_i,
   input  wire logic                    op_mfspr_i,
   input  wire logic                    op_rfe_i,
   input  wire or1k_spr_pkg::operand_t  pc_ctrl_i,
   input  wire or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  wire or1k_spr_pkg::operand_t  spr_wdat_i,
   input  wire or1k_spr_pkg::operand_t  lsu_adr_i,
   input  wire logic                    except_ibus_err_i,
   input  wire logic                    except_illegal_i,
   input  wire logic                    except_align_i,
   input  wire logic                    except_syscall_i,
   input  wire logic                    except_trap_i,
   input  wire logic                    fetch_branch_taken_i,
   input  wire logic [NUM_IRQ-1:0]      irq_i,
   output or1k_spr_pkg::operand_t       mfspr_dat_o,
   output logic                         ctrl_branch_exception_o,
   output or1k_spr_pkg::operand_t       ctrl_branch_except_pc_o,
   output logic                         pipeline_flush_o,
   output or1k_spr_pkg::sr_t            spr_sr_o
);
   import or1k_spr_pkg::*;

   // Shared SPR write strobe for the side blocks
   logic     spr_we;
   operand_t pic_dat;
   operand_t tt_dat;
   logic     pic_irq;
   logic     tt_irq;

   or1k_pic #(
      .NUM_IRQ (NUM_IRQ)
   ) or1k_pic_inst (
      .clk        (clk),
      .rst        (rst),
      .spr_we_i   (spr_we),
      .spr_addr_i (spr_addr_i),
      .spr_wdat_i (spr_wdat_i),
      .irq_i      (irq_i),
      .pic_dat_o  (pic_dat),
      .pic_irq_o  (pic_irq)
   );

   or1k_tick_timer or1k_tick_timer_inst (
      .clk        (clk),
      .rst        (rst),
      .spr_we_i   (spr_we),
      .spr_addr_i (spr_addr_i),
      .spr_wdat_i (spr_wdat_i),
      .tt_dat_o   (tt_dat),
      .tt_irq_o   (tt_irq)
   );

   or1k_supervision_ctrl #(
      .RESET_PC (RESET_PC)
   ) or1k_supervision_ctrl_inst (
      .clk                     (clk),
      .rst                     (rst),
      .padv_ctrl_i             (padv_ctrl_i),
      .op_mtspr_i              (op_mtspr_i),
      .op_mfspr_i              (op_mfspr_i),
      .op_rfe_i                (op_rfe_i),
      .pc_ctrl_i               (pc_ctrl_i),
      .lsu_adr_i               (lsu_adr_i),
      .spr_addr_i              (spr_addr_i),
      .spr_wdat_i              (spr_wdat_i),
      .except_ibus_err_i       (except_ibus_err_i),
      .except_illegal_i        (except_illegal_i),
      .except_align_i          (except_align_i),
      .except_syscall_i        (except_syscall_i),
      .except_trap_i           (except_trap_i),
      .fetch_branch_taken_i    (fetch_branch_taken_i),
      .pic_irq_i               (pic_irq),
      .tt_irq_i                (tt_irq),
      .pic_dat_i               (pic_dat),
      .tt_dat_i                (tt_dat),
      .spr_we_o                (spr_we),
      .mfspr_dat_o             (mfspr_dat_o),
      .ctrl_branch_exception_o (ctrl_branch_exception_o),
      .ctrl_branch_except_pc_o (ctrl_branch_except_pc_o),
      .pipeline_flush_o        (pipeline_flush_o),
      .spr_sr_o                (spr_sr_o)
   );

endmodule

`default_nettype wire

// ==== hw/or1k_supervision_ctrl.sv ====
// Supervision and exception control
`timescale 1ns/100ps
`default_nettype none

module or1k_supervision_ctrl #(
   parameter or1k_spr_pkg::operand_t RESET_PC = 32'h0000_0100
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    padv_ctrl_i,
   input  wire logic                    op_mtspr_i,
   input  wire logic                    op_mfspr_i,
   input  wire logic                    op_rfe_i,
   input  wire or1k_spr_pkg::operand_t  pc_ctrl_i,
   input  wire or1k_spr_pkg::operand_t  lsu_adr_i,
   input  wire or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  wire or1k_spr_pkg::operand_t  spr_wdat_i,
   input  wire logic                    except_ibus_err_i,
   input  wire logic                    except_illegal_i,
   input  wire logic                    except_align_i,
   input  wire logic                    except_syscall_i,
   input  wire logic                    except_trap_i,
   input  wire logic                    fetch_branch_taken_i,
   input  wire logic                    pic_irq_i,
   input  wire logic                    tt_irq_i,
   input  wire or1k_spr_pkg::operand_t  pic_dat_i,
   input  wire or1k_spr_pkg::operand_t  tt_dat_i,
   output logic                         spr_we_o,
   output or1k_spr_pkg::operand_t       mfspr_dat_o,
   output logic                         ctrl_branch_exception_o,
   output or1k_spr_pkg::operand_t       ctrl_branch_except_pc_o,
   output logic                         pipeline_flush_o,
   output or1k_spr_pkg::sr_t            spr_sr_o
);
   import or1k_spr_pkg::*;
   import or1k_except_pkg::*;

   // Software-writable SR bits, FO always reads one
   localparam sr_t SR_WMASK = sr_t'((1 << SR_SM) | (1 << SR_TEE) | (1 << SR_IEE) |
                                    (1 << SR_CY) | (1 << SR_EPH));
   localparam sr_t SR_FO_BIT = sr_t'(1 << SR_FO);
   localparam operand_t EVBAR_MASK = ~operand_t'((1 << EVBAR_LOW_BITS) - 1);

   sr_t         spr_sr;
   sr_t         spr_esr;
   operand_t    spr_epcr;
   operand_t    spr_eear;
   operand_t    spr_evbar;
   operand_t    spr_ppc;
   operand_t    exception_pc_addr;
   operand_t    sys_dat;
   except_vec_t except_vec;
   logic        spr_we;
   logic        except_pic;
   logic        except_tt;
   logic        except_any;
   logic        exception_r;
   logic        exception_taken;
   logic        doing_rfe_r;
   logic        doing_rfe;
   logic        in_progress;
   logic        exception_re;
   logic        rfe_start;

   assign spr_we   = op_mtspr_i & padv_ctrl_i;
   assign spr_we_o = spr_we;

   // Interrupts wait while an mtspr or a return sits in the control stage
   assign except_pic = pic_irq_i & spr_sr[SR_IEE] & ~op_mtspr_i & ~op_rfe_i & ~doing_rfe_r;
   assign except_tt  = tt_irq_i & spr_sr[SR_TEE] & ~op_mtspr_i & ~op_rfe_i & ~doing_rfe_r;

   assign except_any = except_ibus_err_i | except_illegal_i | except_align_i |
                       except_syscall_i | except_trap_i | except_pic | except_tt;

   assign except_vec = rank_cause({except_ibus_err_i, except_illegal_i, except_align_i,
                                   except_syscall_i, except_trap_i, except_pic, except_tt});

   // Entry, return and the cooldown cycle after fetch accepts
   assign in_progress  = exception_r | exception_taken | doing_rfe_r;
   assign exception_re = padv_ctrl_i & except_any & ~in_progress;
   assign rfe_start    = padv_ctrl_i & op_rfe_i & ~except_any & ~in_progress;
   assign doing_rfe    = rfe_start | doing_rfe_r;

   assign ctrl_branch_exception_o = exception_r | doing_rfe;
   assign ctrl_branch_except_pc_o = doing_rfe ? spr_epcr : exception_pc_addr;
   assign pipeline_flush_o        = exception_re | rfe_start;
   assign spr_sr_o                = spr_sr;

   always_ff @(posedge clk) begin
      if (rst) begin
         exception_r     <= 1'b0;
         exception_taken <= 1'b0;
         doing_rfe_r     <= 1'b0;
      end else begin
         exception_taken <= ctrl_branch_exception_o & fetch_branch_taken_i;
         if (exception_re)
            exception_r <= 1'b1;
         else if (fetch_branch_taken_i)
            exception_r <= 1'b0;
         // Fetch may accept the return in its first cycle
         if (rfe_start & ~fetch_branch_taken_i)
            doing_rfe_r <= 1'b1;
         else if (fetch_branch_taken_i)
            doing_rfe_r <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (exception_re)
         exception_pc_addr <= spr_evbar | vec_offset(except_vec);
   end

   always_ff @(posedge clk) begin
      if (rst)
         spr_sr <= SR_RESET_VALUE;
      else if (exception_re) begin
         spr_sr[SR_SM]  <= 1'b1;
         spr_sr[SR_TEE] <= 1'b0;
         spr_sr[SR_IEE] <= 1'b0;
      end else if (rfe_start)
         spr_sr <= spr_esr;
      else if (spr_we && spr_addr_i == SPR_SR_ADDR && spr_sr[SR_SM])
         spr_sr <= (spr_wdat_i[15:0] & SR_WMASK) | SR_FO_BIT;
   end

   always_ff @(posedge clk) begin
      if (rst)
         spr_esr <= SR_RESET_VALUE;
      else if (exception_re)
         spr_esr <= spr_sr;
      else if (spr_we && spr_addr_i == SPR_ESR0_ADDR)
         spr_esr <= spr_wdat_i[15:0];
   end

   // Syscall and interrupts resume after the instruction
   always_ff @(posedge clk) begin
      if (rst)
         spr_epcr <= RESET_PC;
      else if (exception_re) begin
         if (except_vec == VEC_SYSCALL || except_vec == VEC_INT || except_vec == VEC_TT)
            spr_epcr <= pc_ctrl_i + 32'd4;
         else
            spr_epcr <= pc_ctrl_i;
      end else if (spr_we && spr_addr_i == SPR_EPCR0_ADDR)
         spr_epcr <= spr_wdat_i;
   end

   always_ff @(posedge clk) begin
      if (rst)
         spr_eear <= '0;
      else if (exception_re)
         spr_eear <= except_ibus_err_i ? pc_ctrl_i : lsu_adr_i;
      else if (spr_we && spr_addr_i == SPR_EEAR0_ADDR)
         spr_eear <= spr_wdat_i;
   end

   always_ff @(posedge clk) begin
      if (rst)
         spr_evbar <= '0;
      else if (spr_we && spr_addr_i == SPR_EVBAR_ADDR)
         spr_evbar <= spr_wdat_i & EVBAR_MASK;
   end

   // PC of the last completed instruction
   always_ff @(posedge clk) begin
      if (rst)
         spr_ppc <= RESET_PC;
      else if (padv_ctrl_i)
         spr_ppc <= pc_ctrl_i;
   end

   always_comb begin
      case (spr_addr_i)
         SPR_SR_ADDR:    sys_dat = operand_t'(spr_sr);
         SPR_PPC_ADDR:   sys_dat = spr_ppc;
         SPR_EPCR0_ADDR: sys_dat = spr_epcr;
         SPR_EEAR0_ADDR: sys_dat = spr_eear;
         SPR_ESR0_ADDR:  sys_dat = operand_t'(spr_esr);
         SPR_EVBAR_ADDR: sys_dat = spr_evbar;
         default:        sys_dat = '0;
      endcase
   end

   // Group select, only while an mfspr is in the control stage
   always_comb begin
      mfspr_dat_o = '0;
      if (op_mfspr_i) begin
         case (spr_addr_i[15:11])
            SPR_GROUP_SYS: mfspr_dat_o = sys_dat;
            SPR_GROUP_PIC: mfspr_dat_o = pic_dat_i;
            SPR_GROUP_TT:  mfspr_dat_o = tt_dat_i;
            default:       mfspr_dat_o = '0;
         endcase
      end
   end

   // A request starts only from an entry at the last edge or an l.rfe now
   branch_has_cause: assert property (@(posedge clk) disable iff (rst)
      $rose(ctrl_branch_exception_o) |-> $past(exception_re) || rfe_start);

   // EVBAR masking and the vector shift keep entries on 256-byte slots
   vector_aligned: assert property (@(posedge clk) disable iff (rst)
      exception_r |-> exception_pc_addr[7:0] == 8'h00);

endmodule

`default_nettype wire

// ==== hw/or1k_tick_timer.sv ====
// Tick timer
`timescale 1ns/100ps
`default_nettype none

module or1k_tick_timer (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    spr_we_i,
   input  wire or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  wire or1k_spr_pkg::operand_t  spr_wdat_i,
   output or1k_spr_pkg::operand_t       tt_dat_o,
   output logic                         tt_irq_o
);
   import or1k_spr_pkg::*;

   operand_t                 ttmr;
   operand_t                 ttcr;
   logic [1:0]               tt_mode;
   logic [TTMR_PERIOD_W-1:0] tt_period;
   logic                     tt_match;
   logic                     tt_run;
   logic                     ttmr_we;
   logic                     ttcr_we;

   assign tt_mode   = ttmr[TTMR_MODE_LSB +: 2];
   assign tt_period = ttmr[TTMR_PERIOD_W-1:0];

   assign ttmr_we = spr_we_i && spr_addr_i == SPR_TTMR_ADDR;
   assign ttcr_we = spr_we_i && spr_addr_i == SPR_TTCR_ADDR;

   // Mode 00 disables both counting and matching
   assign tt_match = tt_mode != 2'b00 && ttcr == operand_t'(tt_period);

   // One-shot halts on the match
   assign tt_run = tt_mode != 2'b00 && !(tt_mode == TT_MODE_ONESHOT && tt_match);

   always_ff @(posedge clk) begin
      if (rst)
         ttcr <= '0;
      else if (ttcr_we)
         ttcr <= spr_wdat_i;
      else if (tt_run) begin
         if (tt_mode == TT_MODE_RESTART && tt_match)
            ttcr <= '0;
         else
            ttcr <= ttcr + 32'd1;
      end
   end

   // Software clears the pending bit by rewriting TTMR
   always_ff @(posedge clk) begin
      if (rst)
         ttmr <= '0;
      else if (ttmr_we)
         ttmr <= spr_wdat_i;
      else if (tt_match && ttmr[TTMR_IE])
         ttmr[TTMR_IP] <= 1'b1;
   end

   assign tt_irq_o = ttmr[TTMR_IP];

   always_comb begin
      case (spr_addr_i)
         SPR_TTMR_ADDR: tt_dat_o = ttmr;
         SPR_TTCR_ADDR: tt_dat_o = ttcr;
         default:       tt_dat_o = '0;
      endcase
   end

   // Restart mode keeps the count within the period once inside it
   restart_in_range: assert property (@(posedge clk) disable iff (rst)
      (tt_mode == TT_MODE_RESTART && tt_period != '0 &&
       ttcr <= operand_t'(tt_period) && !spr_we_i)
      |=> ttcr <= operand_t'(tt_period));

endmodule

`default_nettype wire

// ==== hw/or1k_pic.sv ====
// Level-triggered interrupt controller
`timescale 1ns/100ps
`default_nettype none

module or1k_pic #(
   parameter int NUM_IRQ = 32
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    spr_we_i,
   input  wire or1k_spr_pkg::spr_addr_t spr_addr_i,
   input  wire or1k_spr_pkg::operand_t  spr_wdat_i,
   input  wire logic [NUM_IRQ-1:0]      irq_i,
   output or1k_spr_pkg::operand_t       pic_dat_o,
   output logic                         pic_irq_o
);
   import or1k_spr_pkg::*;

   logic [NUM_IRQ-1:0] picmr;
   logic [NUM_IRQ-1:0] picsr;
   logic [NUM_IRQ-1:0] mask_next;
   logic               picmr_we;

   assign picmr_we = spr_we_i && spr_addr_i == SPR_PICMR_ADDR;

   // Status uses the mask that is valid after this edge
   assign mask_next = picmr_we ? spr_wdat_i[NUM_IRQ-1:0] : picmr;

   always_ff @(posedge clk) begin
      if (rst) begin
         picmr <= '0;
         picsr <= '0;
      end else begin
         picmr <= mask_next;
         picsr <= irq_i & mask_next;
      end
   end

   assign pic_irq_o = |picsr;

   always_comb begin
      case (spr_addr_i)
         SPR_PICMR_ADDR: pic_dat_o = operand_t'(picmr);
         SPR_PICSR_ADDR: pic_dat_o = operand_t'(picsr);
         default:        pic_dat_o = '0;
      endcase
   end

   // No pending line outside the mask, also across mask writes
   picsr_within_mask: assert property (@(posedge clk) disable iff (rst)
      (picsr & ~picmr) == '0);

endmodule

`default_nettype wire

// ==== hw/or1k_except_pkg.sv ====
// OpenRISC exception vectors
`default_nettype none

package or1k_except_pkg;

   typedef logic [3:0] except_vec_t;

   localparam except_vec_t VEC_BERR    = 4'd2;
   localparam except_vec_t VEC_TT      = 4'd5;
   localparam except_vec_t VEC_ALIGN   = 4'd6;
   localparam except_vec_t VEC_ILLEGAL = 4'd7;
   localparam except_vec_t VEC_INT     = 4'd8;
   localparam except_vec_t VEC_SYSCALL = 4'd12;
   localparam except_vec_t VEC_TRAP    = 4'd14;

   // Table base is 8 KiB aligned
   localparam int EVBAR_LOW_BITS = 13;

   function automatic logic [31:0] vec_offset(input except_vec_t vec);
      return {20'h0, vec, 8'h00};
   endfunction

   // Cause order, MSB first
   // bus error, illegal, alignment, syscall, trap, PIC, tick timer
   function automatic except_vec_t rank_cause(input logic [6:0] cause);
      except_vec_t vec;
      casez (cause)
         7'b1??????: vec = VEC_BERR;
         7'b01?????: vec = VEC_ILLEGAL;
         7'b001????: vec = VEC_ALIGN;
         7'b0001???: vec = VEC_SYSCALL;
         7'b00001??: vec = VEC_TRAP;
         7'b000001?: vec = VEC_INT;
         default:    vec = VEC_TT;
      endcase
      return vec;
   endfunction

endpackage

`default_nettype wire

// ==== hw/or1k_spr_pkg.sv ====
// OpenRISC SPR definitions
`default_nettype none

package or1k_spr_pkg;

   typedef logic [31:0] operand_t;
   typedef logic [15:0] spr_addr_t;
   typedef logic [15:0] sr_t;

   // Group number sits in address bits 15 to 11
   localparam logic [4:0] SPR_GROUP_SYS = 5'd0;
   localparam logic [4:0] SPR_GROUP_PIC = 5'd9;
   localparam logic [4:0] SPR_GROUP_TT  = 5'd10;

   localparam spr_addr_t SPR_EVBAR_ADDR = 16'h000B;
   localparam spr_addr_t SPR_SR_ADDR    = 16'h0011;
   localparam spr_addr_t SPR_PPC_ADDR   = 16'h0012;
   localparam spr_addr_t SPR_EPCR0_ADDR = 16'h0020;
   localparam spr_addr_t SPR_EEAR0_ADDR = 16'h0030;
   localparam spr_addr_t SPR_ESR0_ADDR  = 16'h0040;
   localparam spr_addr_t SPR_PICMR_ADDR = 16'h4800;
   localparam spr_addr_t SPR_PICSR_ADDR = 16'h4802;
   localparam spr_addr_t SPR_TTMR_ADDR  = 16'h5000;
   localparam spr_addr_t SPR_TTCR_ADDR  = 16'h5001;

   // SR bit positions
   localparam int SR_SM  = 0;
   localparam int SR_TEE = 1;
   localparam int SR_IEE = 2;
   localparam int SR_CY  = 10;
   localparam int SR_EPH = 14;
   localparam int SR_FO  = 15;

   // Supervisor mode, fixed-one bit set
   localparam sr_t SR_RESET_VALUE = 16'h8001;

   // TTMR layout
   localparam int TTMR_MODE_LSB = 30;
   localparam int TTMR_IE       = 29;
   localparam int TTMR_IP       = 28;
   localparam int TTMR_PERIOD_W = 28;

   localparam logic [1:0] TT_MODE_RESTART = 2'b01;
   localparam logic [1:0] TT_MODE_ONESHOT = 2'b10;
   localparam logic [1:0] TT_MODE_CONT    = 2'b11;

endpackage

`default_nettype wire
